//--- include/rv_core_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// datapath and address width
`define RV_XLEN 32

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

// register file geometry
`define RV_REG_ADDR_W 5
`define RV_NUM_REGS 32

// byte lanes per data word
`define RV_MASK_W 4

`endif

//--- hdl/rv_core_pkg.sv
`default_nettype none

`include "rv_core_settings.svh"

package rv_core_pkg;

  // shared field view, funct7 only fills the top
  typedef struct packed {
    logic [6:0]                funct7;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [2:0]                funct3;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [6:0]                opcode;
  } common_fmt_t;

  typedef struct packed {
    logic [11:0]               imm;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [2:0]                funct3;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [6:0]                opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]                imm_hi; // imm[11:5]
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [2:0]                funct3;
    logic [4:0]                imm_lo; // imm[4:0]
    logic [6:0]                opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0]               imm; // imm[31:12]
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [6:0]                opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                      imm20;
    logic [9:0]                imm10_1;
    logic                      imm11;
    logic [7:0]                imm19_12;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [6:0]                opcode;
  } j_fmt_t;

  // one instruction word, read through the view its opcode picks
  typedef union packed {
    common_fmt_t c;
    i_fmt_t      i;
    s_fmt_t      s;
    u_fmt_t      u;
    j_fmt_t      j;
  } inst_t;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b011_0111,
    OP_AUIPC  = 7'b001_0111,
    OP_JAL    = 7'b110_1111,
    OP_JALR   = 7'b110_0111,
    OP_LOAD   = 7'b000_0011,
    OP_STORE  = 7'b010_0011,
    OP_IMM    = 7'b001_0011,
    OP_SYSTEM = 7'b111_0011
  } opcode_e;

  typedef enum logic [1:0] {WB_SUM, WB_LINK, WB_LOAD} wb_sel_e;

  typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;

  // standard load/store funct3 codes
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101
  } mem_funct_e;

endpackage

`default_nettype wire

//--- hdl/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_fetch (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                is_jump,
  input  logic                halt_req,
  input  logic [`RV_XLEN-1:0] jump_target,
  output logic [`RV_XLEN-1:0] pc,
  output logic                active,
  output logic                halt
);

  logic [`RV_XLEN-1:0] next_pc;

  assign next_pc = is_jump ? jump_target : pc + `RV_XLEN'(4);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= `RV_RESET_PC;
      active <= 1'b0;
      halt   <= 1'b0;
    end else if (active) begin
      if (halt_req) begin
        // ebreak retires here, pc stays on it until reset
        active <= 1'b0;
        halt   <= 1'b1;
      end else begin
        pc <= next_pc;
      end
    end else if (!halt) begin
      active <= 1'b1; // first edge out of reset
    end
  end

endmodule

`default_nettype wire

//--- hdl/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_decode import rv_core_pkg::*; (
  input  inst_t                     inst,
  input  logic                      active,
  output logic [`RV_REG_ADDR_W-1:0] rs1_addr,
  output logic [`RV_REG_ADDR_W-1:0] rs2_addr,
  output logic [`RV_REG_ADDR_W-1:0] rd_addr,
  output logic                      reg_we,
  output logic [`RV_XLEN-1:0]       imm,
  output op1_sel_e                  op1_sel,
  output wb_sel_e                   wb_sel,
  output logic                      mem_re,
  output logic                      mem_we,
  output mem_funct_e                mem_funct,
  output logic                      is_jump,
  output logic                      halt_req
);

  opcode_e             opcode;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic                load_ok;
  logic                store_ok;
  logic                dec_reg_we;
  logic                dec_mem_re;
  logic                dec_mem_we;
  logic                dec_jump;
  logic                dec_ebreak;

  assign opcode    = opcode_e'(inst.c.opcode);
  assign rs1_addr  = inst.c.rs1;
  assign rs2_addr  = inst.c.rs2;
  assign rd_addr   = inst.c.rd;
  assign mem_funct = mem_funct_e'(inst.c.funct3);

  // sign-extended immediates, one per format
  assign imm_i = {{(`RV_XLEN-12){inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{(`RV_XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_u = {inst.u.imm, 12'h000};
  assign imm_j = {{(`RV_XLEN-21){inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                  inst.j.imm11, inst.j.imm10_1, 1'b0};

  assign load_ok  = inst.c.funct3 inside {MEM_B, MEM_H, MEM_W, MEM_BU, MEM_HU};
  assign store_ok = inst.c.funct3 inside {MEM_B, MEM_H, MEM_W};

  always_comb begin
    imm        = '0;
    op1_sel    = OP1_RS1;
    wb_sel     = WB_SUM;
    dec_reg_we = 1'b0;
    dec_mem_re = 1'b0;
    dec_mem_we = 1'b0;
    dec_jump   = 1'b0;
    dec_ebreak = 1'b0;
    case (opcode)
      OP_LUI: begin
        imm        = imm_u;
        op1_sel    = OP1_ZERO;
        dec_reg_we = 1'b1;
      end
      OP_AUIPC: begin
        imm        = imm_u;
        op1_sel    = OP1_PC;
        dec_reg_we = 1'b1;
      end
      OP_JAL: begin
        imm        = imm_j;
        op1_sel    = OP1_PC;
        wb_sel     = WB_LINK;
        dec_reg_we = 1'b1;
        dec_jump   = 1'b1;
      end
      OP_JALR: begin
        imm        = imm_i;
        wb_sel     = WB_LINK;
        dec_reg_we = 1'b1;
        dec_jump   = 1'b1;
      end
      OP_LOAD: begin
        imm        = imm_i;
        wb_sel     = WB_LOAD;
        dec_reg_we = load_ok;
        dec_mem_re = load_ok; // bad funct3 falls through as a nop
      end
      OP_STORE: begin
        imm        = imm_s;
        dec_mem_we = store_ok;
      end
      OP_IMM: begin
        imm        = imm_i; // every op-imm adds
        dec_reg_we = 1'b1;
      end
      OP_SYSTEM: dec_ebreak = (inst.i.imm == 12'h001) && (inst.c.funct3 == 3'b000);
      default: ; // unknown opcode, just pc + 4
    endcase
  end

  // nothing fires while the core is idle or halted
  assign reg_we   = dec_reg_we & active;
  assign mem_re   = dec_mem_re & active;
  assign mem_we   = dec_mem_we & active;
  assign is_jump  = dec_jump & active;
  assign halt_req = dec_ebreak & active;

endmodule

`default_nettype wire

//--- hdl/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_regfile (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      we,
  input  logic [`RV_REG_ADDR_W-1:0] waddr,
  input  logic [`RV_REG_ADDR_W-1:0] raddr1,
  input  logic [`RV_REG_ADDR_W-1:0] raddr2,
  input  logic [`RV_XLEN-1:0]       wdata,
  output logic [`RV_XLEN-1:0]       rdata1,
  output logic [`RV_XLEN-1:0]       rdata2
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata; // x0 never written
    end
  end

  // x0 reads as zero
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- hdl/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_execute import rv_core_pkg::*; (
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] imm,
  input  logic [`RV_XLEN-1:0] load_data,
  input  op1_sel_e            op1_sel,
  input  wb_sel_e             wb_sel,
  output logic [`RV_XLEN-1:0] sum,
  output logic [`RV_XLEN-1:0] wb_data
);

  logic [`RV_XLEN-1:0] op1;
  logic [`RV_XLEN-1:0] raw_sum;
  logic [`RV_XLEN-1:0] link_addr;

  always_comb begin
    case (op1_sel)
      OP1_RS1: op1 = rs1_data;
      OP1_PC:  op1 = pc;
      default: op1 = '0; // lui
    endcase
  end

  assign raw_sum   = op1 + imm;
  assign link_addr = pc + `RV_XLEN'(4);

  // link ops are jumps, target bit 0 dropped as jalr requires
  // (jal targets are already even)
  assign sum = (wb_sel == WB_LINK) ? {raw_sum[`RV_XLEN-1:1], 1'b0} : raw_sum;

  always_comb begin
    case (wb_sel)
      WB_LINK: wb_data = link_addr;
      WB_LOAD: wb_data = load_data;
      default: wb_data = raw_sum;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_lsu import rv_core_pkg::*; (
  input  logic [`RV_XLEN-1:0]   addr,
  input  logic [`RV_XLEN-1:0]   store_src,
  input  logic [`RV_XLEN-1:0]   mem_rdata,
  input  mem_funct_e            mem_funct,
  input  logic                  mem_re,
  input  logic                  mem_we,
  output logic [`RV_XLEN-1:0]   dmem_addr,
  output logic [`RV_XLEN-1:0]   dmem_wdata,
  output logic [`RV_MASK_W-1:0] dmem_wmask,
  output logic                  dmem_we,
  output logic                  dmem_re,
  output logic [`RV_XLEN-1:0]   load_data
);

  logic [`RV_MASK_W-1:0] lane_mask;
  logic [7:0]            byte_lane;
  logic [15:0]           half_lane;

  assign dmem_addr = addr; // memory sees the full byte address
  assign dmem_we   = mem_we;
  assign dmem_re   = mem_re;

  // store side, data copied into every lane it could land in
  always_comb begin
    case (mem_funct)
      MEM_B: begin
        dmem_wdata = {4{store_src[7:0]}};
        lane_mask  = `RV_MASK_W'(1) << addr[1:0];
      end
      MEM_H: begin
        dmem_wdata = {2{store_src[15:0]}};
        lane_mask  = addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dmem_wdata = store_src; // word, low address bits ignored
        lane_mask  = 4'b1111;
      end
    endcase
  end

  assign dmem_wmask = mem_we ? lane_mask : '0;

  // load side
  always_comb begin
    case (addr[1:0])
      2'd0:    byte_lane = mem_rdata[7:0];
      2'd1:    byte_lane = mem_rdata[15:8];
      2'd2:    byte_lane = mem_rdata[23:16];
      default: byte_lane = mem_rdata[31:24];
    endcase
  end

  assign half_lane = addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  always_comb begin
    case (mem_funct)
      MEM_B:   load_data = {{(`RV_XLEN-8){byte_lane[7]}}, byte_lane};
      MEM_BU:  load_data = {{(`RV_XLEN-8){1'b0}}, byte_lane};
      MEM_H:   load_data = {{(`RV_XLEN-16){half_lane[15]}}, half_lane};
      MEM_HU:  load_data = {{(`RV_XLEN-16){1'b0}}, half_lane};
      default: load_data = mem_rdata;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_core_top import rv_core_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  // instruction memory
  output logic [`RV_XLEN-1:0]   imem_addr,
  input  logic [`RV_XLEN-1:0]   imem_rdata,
  // data memory
  output logic [`RV_XLEN-1:0]   dmem_addr,
  output logic [`RV_XLEN-1:0]   dmem_wdata,
  output logic [`RV_MASK_W-1:0] dmem_wmask,
  output logic                  dmem_we,
  output logic                  dmem_re,
  input  logic [`RV_XLEN-1:0]   dmem_rdata,
  // status
  output logic [`RV_XLEN-1:0]   pc,
  output logic                  halt
);

  inst_t                     inst;
  logic                      active;
  logic                      is_jump;
  logic                      halt_req;
  logic [`RV_REG_ADDR_W-1:0] rs1_addr;
  logic [`RV_REG_ADDR_W-1:0] rs2_addr;
  logic [`RV_REG_ADDR_W-1:0] rd_addr;
  logic                      reg_we;
  logic [`RV_XLEN-1:0]       imm;
  op1_sel_e                  op1_sel;
  wb_sel_e                   wb_sel;
  logic                      mem_re;
  logic                      mem_we;
  mem_funct_e                mem_funct;
  logic [`RV_XLEN-1:0]       rs1_data;
  logic [`RV_XLEN-1:0]       rs2_data;
  logic [`RV_XLEN-1:0]       sum; // alu result, jump target and data address
  logic [`RV_XLEN-1:0]       wb_data;
  logic [`RV_XLEN-1:0]       load_data;

  assign imem_addr = pc;
  assign inst      = imem_rdata;

  rv_fetch u_rv_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .is_jump     (is_jump),
    .halt_req    (halt_req),
    .jump_target (sum),
    .pc          (pc),
    .active      (active),
    .halt        (halt)
  );

  rv_decode u_rv_decode (
    .inst      (inst),
    .active    (active),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rd_addr   (rd_addr),
    .reg_we    (reg_we),
    .imm       (imm),
    .op1_sel   (op1_sel),
    .wb_sel    (wb_sel),
    .mem_re    (mem_re),
    .mem_we    (mem_we),
    .mem_funct (mem_funct),
    .is_jump   (is_jump),
    .halt_req  (halt_req)
  );

  rv_regfile u_rv_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .we     (reg_we),
    .waddr  (rd_addr),
    .raddr1 (rs1_addr),
    .raddr2 (rs2_addr),
    .wdata  (wb_data),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  rv_execute u_rv_execute (
    .pc        (pc),
    .rs1_data  (rs1_data),
    .imm       (imm),
    .load_data (load_data),
    .op1_sel   (op1_sel),
    .wb_sel    (wb_sel),
    .sum       (sum),
    .wb_data   (wb_data)
  );

  rv_lsu u_rv_lsu (
    .addr       (sum),
    .store_src  (rs2_data),
    .mem_rdata  (dmem_rdata),
    .mem_funct  (mem_funct),
    .mem_re     (mem_re),
    .mem_we     (mem_we),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask),
    .dmem_we    (dmem_we),
    .dmem_re    (dmem_re),
    .load_data  (load_data)
  );

endmodule

`default_nettype wire

//--- verification/rv_core_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_core_props (
  input logic                  clk,
  input logic                  rst_n,
  input logic [`RV_XLEN-1:0]   pc,
  input logic                  halt,
  input logic                  dmem_we,
  input logic                  dmem_re,
  input logic [`RV_MASK_W-1:0] dmem_wmask
);

  int fail_count = 0; // read by the testbench at the end

  // one data access per cycle, read or write
  a_no_read_and_write: assert property (@(posedge clk) disable iff (!rst_n)
    !(dmem_we && dmem_re))
    else begin
      $error("dmem_we and dmem_re high together");
      fail_count++;
    end

  a_mask_with_write: assert property (@(posedge clk) disable iff (!rst_n)
    (dmem_wmask != '0) == dmem_we)
    else begin
      $error("dmem_wmask does not follow dmem_we");
      fail_count++;
    end

  a_halt_pc_frozen: assert property (@(posedge clk) disable iff (!rst_n)
    halt |=> $stable(pc))
    else begin
      $error("pc moved while halted");
      fail_count++;
    end

  a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    halt |-> (!dmem_we && !dmem_re))
    else begin
      $error("data strobe high while halted");
      fail_count++;
    end

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    pc[1:0] == 2'b00)
    else begin
      $error("pc not word aligned");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- verification/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_core_tb import rv_core_pkg::*; ();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_PROG     = 64; // instruction words
  localparam int DMEM_WORDS   = 64; // bytes 0x00 to 0xff
  localparam int NUM_TESTS    = 5;
  localparam int HALT_LIMIT   = MAX_PROG + 8;
  // longest program plus reset and halt cycles per test, four times over
  localparam int WATCHDOG_NS  = NUM_TESTS * (MAX_PROG + 2 * 20) * CLK_PERIOD * 4;
  localparam int unsigned SEED = 32'hf84c;
  localparam logic [31:0] BOOT = `RV_RESET_PC;

  logic                  clk;
  logic                  rst_n;
  logic [`RV_XLEN-1:0]   imem_addr;
  logic [`RV_XLEN-1:0]   imem_rdata;
  logic [`RV_XLEN-1:0]   dmem_addr;
  logic [`RV_XLEN-1:0]   dmem_wdata;
  logic [`RV_MASK_W-1:0] dmem_wmask;
  logic                  dmem_we;
  logic                  dmem_re;
  logic [`RV_XLEN-1:0]   dmem_rdata;
  logic [`RV_XLEN-1:0]   pc;
  logic                  halt;

  logic [31:0] imem [0:MAX_PROG-1];
  logic [31:0] dmem [0:DMEM_WORDS-1];
  logic [31:0] exp_mem [0:DMEM_WORDS-1]; // what the ISA says memory should hold
  logic [31:0] imem_off;
  int          prog_len;
  int          errors = 0;
  int          write_count = 0;
  int          read_count = 0;

  rv_core_top u_rv_core_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask),
    .dmem_we    (dmem_we),
    .dmem_re    (dmem_re),
    .dmem_rdata (dmem_rdata),
    .pc         (pc),
    .halt       (halt)
  );

  bind rv_core_top rv_core_props u_rv_core_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc         (pc),
    .halt       (halt),
    .dmem_we    (dmem_we),
    .dmem_re    (dmem_re),
    .dmem_wmask (dmem_wmask)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // combinational-read memories, fetch outside the program reads as zero
  assign imem_off   = imem_addr - BOOT;
  assign imem_rdata = (imem_off < MAX_PROG * 4) ? imem[imem_off[7:2]] : '0;
  assign dmem_rdata = dmem[dmem_addr[7:2]];

  always @(posedge clk) begin
    if (dmem_re) begin
      read_count++;
    end
    if (dmem_we) begin
      write_count++;
      for (int b = 0; b < `RV_MASK_W; b++) begin
        if (dmem_wmask[b]) begin
          dmem[dmem_addr[7:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
        end
      end
    end
  end

  function automatic inst_t make_itype(opcode_e op, logic [4:0] rd, logic [2:0] f3,
                                       logic [4:0] rs1, logic [11:0] imm);
    inst_t w;
    w          = '0;
    w.i.opcode = op;
    w.i.rd     = rd;
    w.i.funct3 = f3;
    w.i.rs1    = rs1;
    w.i.imm    = imm;
    return w;
  endfunction

  function automatic inst_t make_stype(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                       logic [11:0] imm);
    inst_t w;
    w          = '0;
    w.s.opcode = OP_STORE;
    w.s.funct3 = f3;
    w.s.rs1    = rs1;
    w.s.rs2    = rs2;
    w.s.imm_hi = imm[11:5];
    w.s.imm_lo = imm[4:0];
    return w;
  endfunction

  function automatic inst_t make_utype(opcode_e op, logic [4:0] rd, logic [19:0] imm);
    inst_t w;
    w          = '0;
    w.u.opcode = op;
    w.u.rd     = rd;
    w.u.imm    = imm;
    return w;
  endfunction

  function automatic inst_t make_jtype(logic [4:0] rd, logic [20:0] offset);
    inst_t w;
    w            = '0;
    w.j.opcode   = OP_JAL;
    w.j.rd       = rd;
    w.j.imm20    = offset[20];
    w.j.imm10_1  = offset[10:1];
    w.j.imm11    = offset[11];
    w.j.imm19_12 = offset[19:12];
    return w;
  endfunction

  function automatic logic [31:0] sign_extend12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // fill value built from every bit of the byte address
  function automatic logic [31:0] pattern_at(logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a3c_c3a5;
  endfunction

  // load result as the ISA defines it for each funct3
  function automatic logic [31:0] load_value(logic [31:0] word, mem_funct_e f, int off);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*off +: 8];
    h = word[16*(off/2) +: 16];
    case (f)
      MEM_B:   return {{24{b[7]}}, b};
      MEM_BU:  return {24'h0, b};
      MEM_H:   return {{16{h[15]}}, h};
      MEM_HU:  return {16'h0, h};
      default: return word;
    endcase
  endfunction

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("Error: %s: %s expected %08h, actual %08h", test, what, exp, act);
    errors++;
  endtask

  task automatic report_problem(input string test, input string what);
    $display("Error: %s: %s", test, what);
    errors++;
  endtask

  task automatic append_inst(input inst_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  task automatic append_ebreak();
    append_inst(make_itype(OP_SYSTEM, 5'd0, 3'b000, 5'd0, 12'h001));
  endtask

  // lui plus addi, upper part rounded for the sign of the low 12 bits
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] hi;
    hi = value + 32'h800;
    append_inst(make_utype(OP_LUI, rd, hi[31:12]));
    append_inst(make_itype(OP_IMM, rd, 3'b000, rd, value[11:0]));
  endtask

  task automatic prepare_test();
    for (int i = 0; i < MAX_PROG; i++) begin
      imem[i] = '0;
    end
    prog_len = 0;
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i]    <= pattern_at(32'(i * 4));
      exp_mem[i]  = pattern_at(32'(i * 4));
    end
  endtask

  task automatic reset_core(input string name);
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #1;
      if (pc !== BOOT) report_mismatch(name, "pc in reset", BOOT, pc);
      if (halt !== 1'b0) report_mismatch(name, "halt in reset", 32'd0, 32'(halt));
      if (dmem_we !== 1'b0 || dmem_re !== 1'b0) begin
        report_problem(name, "data memory strobe high during reset");
      end
    end
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    // core just went active, nothing retired yet
    if (pc !== BOOT) report_mismatch(name, "pc after reset", BOOT, pc);
    if (halt !== 1'b0) report_mismatch(name, "halt after reset", 32'd0, 32'(halt));
  endtask

  task automatic run_program(input string name);
    int cycles;
    reset_core(name);
    cycles = 0;
    while (halt !== 1'b1 && cycles < HALT_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (halt !== 1'b1) report_problem(name, "core never halted on ebreak");
  endtask

  task automatic check_memory(input string name);
    for (int i = 0; i < DMEM_WORDS; i++) begin
      if (dmem[i] !== exp_mem[i]) begin
        report_mismatch(name, $sformatf("dmem word %0d", i), exp_mem[i], dmem[i]);
      end
    end
  endtask

  task automatic test_arith();
    logic [19:0] u1;
    logic [19:0] u2;
    logic [11:0] a;
    logic [11:0] b;
    u1 = 20'($urandom);
    u2 = 20'($urandom);
    a  = 12'($urandom);
    b  = 12'($urandom);
    prepare_test();
    append_inst(make_utype(OP_LUI, 5'd1, u1));
    append_inst(make_utype(OP_AUIPC, 5'd2, u2)); // sits at BOOT + 4
    append_inst(make_itype(OP_IMM, 5'd3, 3'b000, 5'd1, a));
    append_inst(make_itype(OP_IMM, 5'd4, 3'b000, 5'd0, b));
    for (int r = 1; r <= 4; r++) begin
      append_inst(make_stype(MEM_W, 5'd0, 5'(r), 12'(4 * (r - 1))));
    end
    append_ebreak();
    exp_mem[0] = {u1, 12'h000};
    exp_mem[1] = BOOT + 32'd4 + {u2, 12'h000};
    exp_mem[2] = {u1, 12'h000} + sign_extend12(a);
    exp_mem[3] = sign_extend12(b);
    run_program("arith");
    check_memory("arith");
  endtask

  task automatic test_stores();
    logic [31:0] v;
    v = $urandom;
    prepare_test();
    load_const(5'd5, v);
    // one sb per word so the untouched lanes stay visible
    for (int off = 0; off < 4; off++) begin
      append_inst(make_stype(MEM_B, 5'd0, 5'd5, 12'(16 + 5 * off)));
      exp_mem[4 + off][8*off +: 8] = v[7:0];
    end
    for (int k = 0; k < 2; k++) begin
      append_inst(make_stype(MEM_H, 5'd0, 5'd5, 12'(32 + 6 * k)));
      exp_mem[8 + k][16*k +: 16] = v[15:0];
    end
    append_inst(make_stype(MEM_W, 5'd0, 5'd5, 12'd40));
    exp_mem[10] = v;
    append_ebreak();
    run_program("stores");
    check_memory("stores");
  endtask

  task automatic add_load(input logic [31:0] src, input mem_funct_e f, input int off,
                          inout int slot);
    append_inst(make_itype(OP_LOAD, 5'd7, f, 5'd0, 12'(40 + off)));
    append_inst(make_stype(MEM_W, 5'd0, 5'd7, 12'(64 + 4 * slot)));
    exp_mem[16 + slot] = load_value(src, f, off);
    slot++;
  endtask

  task automatic test_loads();
    logic [31:0] src;
    int          slot;
    int          reads;
    // bytes 1 and 2 negative, so both extensions show
    src = ($urandom & 32'h7f7f_7f7f) | 32'h0080_8000;
    slot = 0;
    prepare_test();
    dmem[10]    <= src;
    exp_mem[10]  = src;
    for (int off = 0; off < 4; off++) begin
      add_load(src, MEM_B, off, slot);
      add_load(src, MEM_BU, off, slot);
    end
    for (int off = 0; off < 4; off += 2) begin
      add_load(src, MEM_H, off, slot);
      add_load(src, MEM_HU, off, slot);
    end
    add_load(src, MEM_W, 0, slot);
    append_ebreak();
    reads = read_count;
    run_program("loads");
    // one read strobe per load, none for the stores
    if (read_count - reads != slot) begin
      report_mismatch("loads", "data memory reads", 32'(slot), 32'(read_count - reads));
    end
    check_memory("loads");
  endtask

  task automatic test_jumps();
    prepare_test();
    append_inst(make_jtype(5'd1, 21'd8));                        // jal over the next word
    append_inst(make_stype(MEM_W, 5'd0, 5'd0, 12'd120));          // skipped
    append_inst(make_stype(MEM_W, 5'd0, 5'd1, 12'd96));
    append_inst(make_utype(OP_AUIPC, 5'd2, 20'd0));               // x2 = BOOT + 12
    append_inst(make_itype(OP_JALR, 5'd3, 3'b000, 5'd2, 12'd13)); // odd target
    append_inst(make_stype(MEM_W, 5'd0, 5'd0, 12'd124));          // skipped
    append_inst(make_stype(MEM_W, 5'd0, 5'd3, 12'd100));
    append_ebreak();
    exp_mem[24] = BOOT + 32'd4;
    exp_mem[25] = BOOT + 32'd20;
    run_program("jumps");
    // ebreak word reached only through an even jalr target
    if (pc !== BOOT + 32'd28) report_mismatch("jumps", "halt pc", BOOT + 32'd28, pc);
    check_memory("jumps");
  endtask

  task automatic test_halt();
    logic [11:0] a;
    logic [31:0] halt_pc;
    int          writes;
    a = 12'($urandom);
    prepare_test();
    append_inst(make_itype(OP_IMM, 5'd1, 3'b000, 5'd0, a));
    append_inst(make_stype(MEM_W, 5'd0, 5'd1, 12'd128));
    append_ebreak();
    append_inst(make_stype(MEM_W, 5'd0, 5'd1, 12'd132)); // past the ebreak
    exp_mem[32] = sign_extend12(a);
    run_program("halt");
    halt_pc = pc;
    writes  = write_count;
    if (halt_pc !== BOOT + 32'd8) report_mismatch("halt", "halt pc", BOOT + 32'd8, halt_pc);
    repeat (20) begin
      @(posedge clk);
      #1;
      if (pc !== halt_pc) report_mismatch("halt", "frozen pc", halt_pc, pc);
      if (halt !== 1'b1) report_mismatch("halt", "halt level", 32'd1, 32'(halt));
      if (dmem_we !== 1'b0 || dmem_re !== 1'b0) begin
        report_problem("halt", "data memory strobe high after halt");
      end
    end
    if (write_count != writes) report_problem("halt", "data memory written after halt");
    check_memory("halt");
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Error: watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int assert_fails;
    void'($urandom(SEED));
    rst_n = 1'b0;
    prepare_test();
    test_arith();
    test_stores();
    test_loads();
    test_jumps();
    test_halt();
    assert_fails = u_rv_core_top.u_rv_core_props.fail_count;
    $display("Summary: %0d check errors, %0d assertion failures", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_core.f
+incdir+include
hdl/rv_core_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_lsu.sv
hdl/rv_core_top.sv
verification/rv_core_props.sv
verification/rv_core_tb.sv
